/* source/fp_pkg.sv */
package fp_pkg;

	// ieee 754 single precision layout
	typedef logic [31:0] fp32_t;      // sign, exponent, fraction
	typedef logic [7:0]  exp_t;       // biased exponent
	typedef logic [8:0]  exp_wide_t;  // room for carry or borrow
	typedef logic [23:0] sig_t;       // hidden bit plus 23 fraction bits

	localparam exp_t EXP_BIAS = 8'd127;
	localparam exp_t EXP_MAX  = 8'd255;  // inf and nan exponent

	// quiet nan with the sign set, returned for inf-inf and 0*inf
	localparam fp32_t FP_DEFAULT_NAN = 32'hffc0_0000;

	// issue to output, in clock cycles
	localparam int FPU_LATENCY = 4;

endpackage

/* source/fpu_op_pkg.sv */
package fpu_op_pkg;

	// instruction fields, as split by the decoder of the cpu
	typedef logic [5:0] op1_t;    // bits 31:26
	typedef logic [4:0] fmt_t;    // bits 25:21
	typedef logic [5:0] funct_t;  // bits 5:0

	typedef logic [3:0] exc_t;

	localparam op1_t OP1_COP1 = 6'b010001;
	localparam fmt_t FMT_S    = 5'b10000;  // single precision

	localparam funct_t FUNCT_ADD = 6'd0;
	localparam funct_t FUNCT_SUB = 6'd1;
	localparam funct_t FUNCT_MUL = 6'd2;
	localparam funct_t FUNCT_ABS = 6'd5;
	localparam funct_t FUNCT_NEG = 6'd7;

	// op_none only comes out of reset
	typedef enum logic [2:0] {
		OP_NONE,
		OP_ADD,
		OP_SUB,
		OP_MUL,
		OP_ABS,
		OP_NEG,
		OP_INVALID
	} fpu_op_e;

	localparam exc_t EXC_NONE       = 4'b0000;
	localparam exc_t EXC_OVF        = 4'b0001;
	localparam exc_t EXC_INVALID_OP = 4'b1000;

endpackage

/* source/fp_operand_if.sv */
`timescale 1ns/10ps

// one operand after unpacking, shared by both arithmetic units
interface fp_operand_if;
	import fp_pkg::*;

	logic  sign;
	exp_t  exp;      // denormals carry exponent 1
	sig_t  sig;      // hidden bit set for normals
	logic  is_zero;
	logic  is_inf;
	logic  is_nan;
	fp32_t raw;      // original word, for nan payloads and magnitude compare

	modport producer (output sign, exp, sig, is_zero, is_inf, is_nan, raw);
	modport consumer (input sign, exp, sig, is_zero, is_inf, is_nan, raw);

endinterface

/* source/fp_unpack.sv */
`timescale 1ns/10ps

module fp_unpack (
	input  fp_pkg::fp32_t  x,
	fp_operand_if.producer op
);
	import fp_pkg::*;

	logic denorm;
	logic frac_nz;
	logic exp_max;

	assign denorm  = x[30:23] == 8'd0;
	assign frac_nz = |x[22:0];
	assign exp_max = x[30:23] == EXP_MAX;

	assign op.sign = x[31];
	// true exponent of a denormal is -126, same as biased 1
	assign op.exp  = denorm ? 8'd1 : x[30:23];
	assign op.sig  = {~denorm, x[22:0]};

	assign op.is_zero = denorm & ~frac_nz;
	assign op.is_inf  = exp_max & ~frac_nz;
	assign op.is_nan  = exp_max & frac_nz;
	assign op.raw     = x;

endmodule

/* source/lead_zero_count.sv */
`timescale 1ns/10ps

// counts zeros above the highest set bit, WIDTH when all clear
module lead_zero_count #(
	parameter int WIDTH = 27
) (
	input  logic [WIDTH-1:0]           value,
	output logic [$clog2(WIDTH+1)-1:0] count
);

	int n;

	always_comb begin
		n = WIDTH;
		// scan upward so the highest set bit wins
		for (int i = 0; i < WIDTH; i++) begin
			if (value[i]) begin
				n = WIDTH - 1 - i;
			end
		end
		count = n[$clog2(WIDTH+1)-1:0];
	end

endmodule

/* source/fp_addsub.sv */
`timescale 1ns/10ps

module fp_addsub (
	input  logic           clk,
	input  logic           sub,  // 1 flips the sign of b
	fp_operand_if.consumer a,
	fp_operand_if.consumer b,
	output fp_pkg::fp32_t  y,
	output logic           ovf
);
	import fp_pkg::*;

	logic        sb;        // effective sign of b
	logic        a_ge;      // |a| >= |b|
	logic        eff_sub;
	logic        sw;        // sign of the larger operand
	exp_t        ew, el;
	sig_t        mw, ml;
	exp_t        eshift;
	logic [48:0] ml_sh;
	logic [26:0] ml_al;     // sig 24 + guard + round + sticky
	logic [27:0] m_sum;
	logic [26:0] m_dif;
	logic [4:0]  lz;
	exp_t        lsh;
	logic [26:0] m_n;
	exp_wide_t   e_n;
	logic        rnd_up;
	logic [24:0] m_r;       // carry + 24 bit significand
	exp_wide_t   e_r;
	logic        ovf_n;
	logic        sy;
	fp32_t       y_n;
	logic        ovf_fin;

	//////////////////////////////////////////////////////////////////////
	// order by magnitude and align the smaller operand

	always_comb begin
		sb      = b.sign ^ sub;
		a_ge    = a.raw[30:0] >= b.raw[30:0];
		eff_sub = a.sign != sb;
		sw      = a_ge ? a.sign : sb;
		ew      = a_ge ? a.exp : b.exp;
		el      = a_ge ? b.exp : a.exp;
		mw      = a_ge ? a.sig : b.sig;
		ml      = a_ge ? b.sig : a.sig;
		eshift  = ew - el;
		ml_sh   = {ml, 25'd0} >> eshift;
		ml_al   = {ml_sh[48:23], |ml_sh[22:0]};
		m_sum   = {1'b0, mw, 3'd0} + {1'b0, ml_al};
		m_dif   = {mw, 3'd0} - ml_al;  // never negative, mw is the larger
	end

	lead_zero_count #(.WIDTH(27)) u_lzc (
		.value (m_dif),
		.count (lz)
	);

	//////////////////////////////////////////////////////////////////////
	// renormalize, round to nearest even, special values

	always_comb begin
		lsh = '0;
		if (!eff_sub) begin
			if (m_sum[27]) begin  // carry out, shift right keeping sticky
				m_n = {m_sum[27:2], |m_sum[1:0]};
				e_n = {1'b0, ew} + 9'd1;
			end else begin
				m_n = m_sum[26:0];
				e_n = {1'b0, ew};
			end
		end else begin
			// stop at exponent 1, below that the result is denormal
			lsh = ({3'b0, lz} < ew) ? {3'b0, lz} : ew - 8'd1;
			m_n = m_dif << lsh;
			e_n = {1'b0, ew - lsh};
		end

		rnd_up = m_n[2] & (m_n[3] | m_n[1] | m_n[0]);
		m_r    = {1'b0, m_n[26:3]} + {24'd0, rnd_up};
		e_r    = e_n + {8'd0, m_r[24]};
		ovf_n  = e_r >= {1'b0, EXP_MAX};
		sy     = (eff_sub && m_n == '0) ? 1'b0 : sw;  // x-x is +0

		if (a.is_nan) begin
			y_n = {a.raw[31:23], 1'b1, a.raw[21:0]};
		end else if (b.is_nan) begin
			y_n = {b.raw[31:23], 1'b1, b.raw[21:0]};
		end else if (a.is_inf && b.is_inf && eff_sub) begin
			y_n = FP_DEFAULT_NAN;
		end else if (a.is_inf) begin
			y_n = {a.sign, EXP_MAX, 23'd0};
		end else if (b.is_inf) begin
			y_n = {sb, EXP_MAX, 23'd0};
		end else if (ovf_n) begin
			y_n = {sy, EXP_MAX, 23'd0};
		end else begin
			y_n = {sy, (m_r[24] | m_r[23]) ? e_r[7:0] : 8'd0, m_r[22:0]};
		end

		ovf_fin = ovf_n & ~(a.is_nan | a.is_inf | b.is_nan | b.is_inf);
	end

	always_ff @(posedge clk) begin
		y   <= y_n;
		ovf <= ovf_fin;
	end

endmodule

/* source/fp_mul.sv */
`timescale 1ns/10ps

module fp_mul (
	input  logic           clk,
	fp_operand_if.consumer a,
	fp_operand_if.consumer b,
	output fp_pkg::fp32_t  y,
	output logic           ovf
);
	import fp_pkg::*;

	logic        sy;
	exp_wide_t   e_sum;     // ea + eb, bias counted twice
	exp_wide_t   rsh;
	logic        den;       // result lands in the denormal range
	logic [47:0] p;         // product, hidden bit at 46 or 47
	logic [95:0] p_den_sh;
	logic [47:0] p_al;
	exp_wide_t   e_al;
	logic [5:0]  lz;
	exp_wide_t   lsh;
	logic [47:0] p_n;
	exp_wide_t   e_n;
	logic        rnd_up;
	logic [24:0] m_r;
	exp_wide_t   e_r;
	logic        ovf_n;
	logic        any_special;
	fp32_t       y_n;

	//////////////////////////////////////////////////////////////////////
	// significand product and exponent sum

	always_comb begin
		sy    = a.sign ^ b.sign;
		p     = a.sig * b.sig;
		e_sum = {1'b0, a.exp} + {1'b0, b.exp};
		den   = (e_sum < {1'b0, EXP_BIAS}) || (e_sum == {1'b0, EXP_BIAS} && !p[47]);

		// denormal: shift right by 128 - e_sum with exponent 1
		rsh      = {1'b0, EXP_BIAS} + 9'd1 - e_sum;
		p_den_sh = {p, 48'd0} >> rsh;

		if (den) begin
			p_al = {p_den_sh[95:49], |p_den_sh[48:0]};
			e_al = 9'd1;
		end else if (p[47]) begin
			p_al = {1'b0, p[47:2], |p[1:0]};
			e_al = e_sum - {1'b0, EXP_BIAS} + 9'd1;
		end else begin
			p_al = p;
			e_al = e_sum - {1'b0, EXP_BIAS};
		end
	end

	lead_zero_count #(.WIDTH(47)) u_lzc (
		.value (p_al[46:0]),
		.count (lz)
	);

	//////////////////////////////////////////////////////////////////////
	// left normalize denormal inputs, round, special values

	always_comb begin
		lsh = ({3'b0, lz} < e_al) ? {3'b0, lz} : e_al - 9'd1;
		p_n = p_al << lsh;
		e_n = e_al - lsh;

		// sig at 46:23, guard at 22, sticky below
		rnd_up = p_n[22] & (p_n[23] | (|p_n[21:0]));
		m_r    = {1'b0, p_n[46:23]} + {24'd0, rnd_up};
		e_r    = e_n + {8'd0, m_r[24]};
		ovf_n  = e_r >= {1'b0, EXP_MAX};

		any_special = a.is_nan | a.is_inf | b.is_nan | b.is_inf;

		if (a.is_nan) begin
			y_n = {a.raw[31:23], 1'b1, a.raw[21:0]};
		end else if (b.is_nan) begin
			y_n = {b.raw[31:23], 1'b1, b.raw[21:0]};
		end else if ((a.is_inf && b.is_zero) || (a.is_zero && b.is_inf)) begin
			y_n = FP_DEFAULT_NAN;
		end else if (a.is_inf || b.is_inf) begin
			y_n = {sy, EXP_MAX, 23'd0};
		end else if (ovf_n) begin
			y_n = {sy, EXP_MAX, 23'd0};  // saturate
		end else begin
			y_n = {sy, (m_r[24] | m_r[23]) ? e_r[7:0] : 8'd0, m_r[22:0]};
		end
	end

	always_ff @(posedge clk) begin
		y   <= y_n;
		ovf <= ovf_n & ~any_special;
	end

endmodule

/* source/fpu_result_stage.sv */
`timescale 1ns/10ps

module fpu_result_stage (
	input  logic               clk,
	input  logic               rstn,
	input  fpu_op_pkg::op1_t   op1,
	input  fpu_op_pkg::fmt_t   fmt,
	input  fpu_op_pkg::funct_t funct,
	input  fp_pkg::fp32_t      x1,
	input  fp_pkg::fp32_t      y_addsub,
	input  logic               ovf_addsub,
	input  fp_pkg::fp32_t      y_mul,
	input  logic               ovf_mul,
	output fp_pkg::fp32_t      y,
	output fpu_op_pkg::exc_t   exception
);
	import fp_pkg::*;
	import fpu_op_pkg::*;

	fpu_op_e op_dec;
	fpu_op_e op_s1;    // lines up with the unit result registers
	fp32_t   x1_s1;
	fp32_t   y_sel;
	exc_t    exc_sel;
	fp32_t   y_dly   [FPU_LATENCY-1];
	exc_t    exc_dly [FPU_LATENCY-1];

	//////////////////////////////////////////////////////////////////////
	// decode at issue

	always_comb begin
		op_dec = OP_INVALID;
		if (op1 == OP1_COP1 && fmt == FMT_S) begin
			case (funct)
				FUNCT_ADD: op_dec = OP_ADD;
				FUNCT_SUB: op_dec = OP_SUB;
				FUNCT_MUL: op_dec = OP_MUL;
				FUNCT_ABS: op_dec = OP_ABS;
				FUNCT_NEG: op_dec = OP_NEG;
				default:   op_dec = OP_INVALID;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			op_s1 <= OP_NONE;
		end else begin
			op_s1 <= op_dec;
		end
	end

	always_ff @(posedge clk) begin
		x1_s1 <= x1;
	end

	//////////////////////////////////////////////////////////////////////
	// stage 1 select, then the output delay line

	always_comb begin
		y_sel   = '0;
		exc_sel = EXC_NONE;
		case (op_s1)
			OP_ADD, OP_SUB: begin
				y_sel   = y_addsub;
				exc_sel = ovf_addsub ? EXC_OVF : EXC_NONE;
			end
			OP_MUL: begin
				y_sel   = y_mul;
				exc_sel = ovf_mul ? EXC_OVF : EXC_NONE;
			end
			OP_ABS:     y_sel = {1'b0, x1_s1[30:0]};
			OP_NEG:     y_sel = {~x1_s1[31], x1_s1[30:0]};
			OP_INVALID: exc_sel = EXC_INVALID_OP;  // y stays 0
			default:    y_sel = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < FPU_LATENCY - 1; i++) begin
				y_dly[i]   <= '0;
				exc_dly[i] <= EXC_NONE;
			end
		end else begin
			y_dly[0]   <= y_sel;
			exc_dly[0] <= exc_sel;
			for (int i = 1; i < FPU_LATENCY - 1; i++) begin
				y_dly[i]   <= y_dly[i-1];
				exc_dly[i] <= exc_dly[i-1];
			end
		end
	end

	assign y         = y_dly[FPU_LATENCY-2];
	assign exception = exc_dly[FPU_LATENCY-2];

endmodule

/* source/fpu_top.sv */
`timescale 1ns/10ps

module fpu_top (
	input  logic               clk,
	input  logic               rstn,
	input  fpu_op_pkg::op1_t   op1,
	input  fpu_op_pkg::fmt_t   fmt,
	input  fpu_op_pkg::funct_t funct,
	input  fp_pkg::fp32_t      x1,
	input  fp_pkg::fp32_t      x2,
	output fp_pkg::fp32_t      y,
	output fpu_op_pkg::exc_t   exception
);
	import fp_pkg::*;
	import fpu_op_pkg::*;

	fp32_t y_addsub;
	fp32_t y_mul;
	logic  ovf_addsub;
	logic  ovf_mul;
	logic  sub;

	fp_operand_if opa ();
	fp_operand_if opb ();

	assign sub = funct[0];  // add and sub differ only in bit 0

	fp_unpack u_unpack_a (.x(x1), .op(opa.producer));
	fp_unpack u_unpack_b (.x(x2), .op(opb.producer));

	fp_addsub u_addsub (
		.clk (clk),
		.sub (sub),
		.a   (opa.consumer),
		.b   (opb.consumer),
		.y   (y_addsub),
		.ovf (ovf_addsub)
	);

	fp_mul u_mul (
		.clk (clk),
		.a   (opa.consumer),
		.b   (opb.consumer),
		.y   (y_mul),
		.ovf (ovf_mul)
	);

	fpu_result_stage u_result (
		.clk        (clk),
		.rstn       (rstn),
		.op1        (op1),
		.fmt        (fmt),
		.funct      (funct),
		.x1         (x1),
		.y_addsub   (y_addsub),
		.ovf_addsub (ovf_addsub),
		.y_mul      (y_mul),
		.ovf_mul    (ovf_mul),
		.y          (y),
		.exception  (exception)
	);

endmodule

/* test/fpu_checker.sv */
`timescale 1ns/10ps

module fpu_checker (
	input logic               clk,
	input logic               rstn,
	input fpu_op_pkg::op1_t   op1,
	input fpu_op_pkg::fmt_t   fmt,
	input fpu_op_pkg::funct_t funct,
	input fp_pkg::fp32_t      x1,
	input fp_pkg::fp32_t      y,
	input fpu_op_pkg::exc_t   exception
);
	import fp_pkg::*;
	import fpu_op_pkg::*;

	int unsigned fails    = 0;  // read by the testbench
	int unsigned edges    = 0;  // saturating count of rising edges
	int unsigned up_edges = 0;  // consecutive edges with rstn high
	logic        op_valid;
	logic        settled;
	logic        filling;
	fp32_t       x1_dly [FPU_LATENCY];  // x1 as issued, newest first
	fp32_t       abs_exp;
	fp32_t       neg_exp;

	assign op_valid = op1 == OP1_COP1 && fmt == FMT_S &&
		funct inside {FUNCT_ADD, FUNCT_SUB, FUNCT_MUL, FUNCT_ABS, FUNCT_NEG};

	always @(posedge clk) begin
		if (edges < 255) edges <= edges + 1;
		if (!rstn) begin
			up_edges <= 0;
		end else if (up_edges < 255) begin
			up_edges <= up_edges + 1;
		end
	end

	always @(posedge clk) begin
		x1_dly[0] <= x1;
		for (int i = 1; i < FPU_LATENCY; i++) begin
			x1_dly[i] <= x1_dly[i-1];
		end
	end

	// sign bit cleared or flipped on the operand issued four edges back
	assign abs_exp = x1_dly[FPU_LATENCY-1] & 32'h7fff_ffff;
	assign neg_exp = x1_dly[FPU_LATENCY-1] ^ 32'h8000_0000;

	// the whole pipe holds instructions issued out of reset
	assign settled = up_edges >= FPU_LATENCY;
	assign filling = edges != 0 && up_edges < FPU_LATENCY;

	a_reset_zero: assert property (@(posedge clk)
		filling |-> (y == '0 && exception == EXC_NONE))
		else begin
			$error("at %0t y=%h exception=%b, expected y=0 exception=0000 after reset",
				$time, y, exception);
			fails++;
		end

	a_abs: assert property (@(posedge clk)
		(settled && $past(op_valid, FPU_LATENCY) && $past(funct, FPU_LATENCY) == FUNCT_ABS)
		|-> (y == abs_exp && exception == EXC_NONE))
		else begin
			$error("at %0t abs gave y=%h exception=%b, expected y=%h exception=%b",
				$time, y, exception, abs_exp, EXC_NONE);
			fails++;
		end

	a_neg: assert property (@(posedge clk)
		(settled && $past(op_valid, FPU_LATENCY) && $past(funct, FPU_LATENCY) == FUNCT_NEG)
		|-> (y == neg_exp && exception == EXC_NONE))
		else begin
			$error("at %0t neg gave y=%h exception=%b, expected y=%h exception=%b",
				$time, y, exception, neg_exp, EXC_NONE);
			fails++;
		end

	// unknown opcode fields
	a_invalid: assert property (@(posedge clk)
		(settled && !$past(op_valid, FPU_LATENCY))
		|-> (y == '0 && exception == EXC_INVALID_OP))
		else begin
			$error("at %0t invalid op gave y=%h exception=%b, expected y=0 exception=%b",
				$time, y, exception, EXC_INVALID_OP);
			fails++;
		end

	a_valid: assert property (@(posedge clk)
		(settled && $past(op_valid, FPU_LATENCY)) |-> exception != EXC_INVALID_OP)
		else begin
			$error("at %0t valid op gave exception=%b, expected anything but %b",
				$time, exception, EXC_INVALID_OP);
			fails++;
		end

endmodule

bind fpu_top fpu_checker chk0 (
	.clk       (clk),
	.rstn      (rstn),
	.op1       (op1),
	.fmt       (fmt),
	.funct     (funct),
	.x1        (x1),
	.y         (y),
	.exception (exception)
);

/* test/fpu_tb.sv */
`timescale 1ns/10ps

module fpu_tb;
	import fp_pkg::*;
	import fpu_op_pkg::*;

	logic   clk;
	logic   rstn;
	op1_t   op1;
	fmt_t   fmt;
	funct_t funct;
	fp32_t  x1;
	fp32_t  x2;
	fp32_t  y;
	exc_t   exception;

	int seed   = 32'hbf19;
	int n_rand = 32;  // random operations per kind

	// expected results with the oldest at the front
	fp32_t exp_y_q[$];
	exc_t  exp_exc_q[$];
	bit    chk_q[$];

	fpu_top dut0 (
		.clk       (clk),
		.rstn      (rstn),
		.op1       (op1),
		.fmt       (fmt),
		.funct     (funct),
		.x1        (x1),
		.x2        (x2),
		.y         (y),
		.exception (exception)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		int limit;
		limit = (5 * n_rand + 15 + 20) * 40;  // issued ops plus margin in ns
		#(limit);
		$display("Timeout: the test did not finish in time");
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

	always @(negedge clk) begin
		if (dut0.chk0.fails != 0) begin
			$display("Checker assertion failed by %0t, see the error above", $time);
			$display("Test FAILED");
			$fatal(1, "stopped on checker failure");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reference values

	// exact for magnitudes below 2^23
	function automatic fp32_t int_to_fp(input int v);
		logic        s;
		int          mag;
		int          e;
		logic [31:0] m;
		s   = v < 0;
		mag = s ? -v : v;
		if (mag == 0) begin
			return '0;
		end
		e = 30;
		while (!mag[e]) begin
			e--;
		end
		m = mag << (23 - e);  // leading one lands on the hidden bit 23
		return {s, 8'(e + 127), m[22:0]};
	endfunction

	function automatic fp32_t pow2(input int k, input logic s);
		return {s, 8'(k + 127), 23'd0};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// issue and compare

	task automatic check_oldest();
		fp32_t ey;
		exc_t  ee;
		bit    chk;
		ey  = exp_y_q.pop_front();
		ee  = exp_exc_q.pop_front();
		chk = chk_q.pop_front();
		if (chk) begin
			assert (y == ey) else begin
				$display("** Error at %0t: y is %h, expected %h", $time, y, ey);
				$display("Test FAILED");
				$fatal(1, "result mismatch");
			end
			assert (exception == ee) else begin
				$display("** Error at %0t: exception is %b, expected %b", $time, exception, ee);
				$display("Test FAILED");
				$fatal(1, "exception mismatch");
			end
		end
	endtask

	// result of an op driven here shows up four falling edges later
	task automatic issue(input op1_t o, input fmt_t f, input funct_t fn,
		input fp32_t a, input fp32_t b, input bit chk, input fp32_t ey, input exc_t ee);
		@(negedge clk);
		if (chk_q.size() == FPU_LATENCY) begin
			check_oldest();
		end
		op1   = o;
		fmt   = f;
		funct = fn;
		x1    = a;
		x2    = b;
		chk_q.push_back(chk);
		exp_y_q.push_back(ey);
		exp_exc_q.push_back(ee);
	endtask

	task automatic run_op(input funct_t fn, input fp32_t a, input fp32_t b,
		input bit chk, input fp32_t ey, input exc_t ee);
		issue(OP1_COP1, FMT_S, fn, a, b, chk, ey, ee);
	endtask

	task automatic drain_pipe();
		while (chk_q.size() != 0) begin
			@(negedge clk);
			check_oldest();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		int    a;
		int    b;
		fp32_t r;
		logic  sgn;

		rstn  = 1'b0;
		// an overflowing product gives nonzero y and exception unless reset clears the pipe
		op1   = OP1_COP1;
		fmt   = FMT_S;
		funct = FUNCT_MUL;
		x1    = pow2(100, 1'b0);
		x2    = pow2(100, 1'b0);
		repeat (4) @(negedge clk);
		rstn = 1'b1;

		// abs and neg on any bit pattern go to the bound checker
		repeat (n_rand) begin
			r = $random(seed);
			run_op(FUNCT_ABS, r, '0, 1'b0, '0, EXC_NONE);
			r = $random(seed);
			run_op(FUNCT_NEG, r, '0, 1'b0, '0, EXC_NONE);
		end

		repeat (n_rand) begin
			a = $random(seed) % 2048;
			b = $random(seed) % 2048;
			run_op(FUNCT_ADD, int_to_fp(a), int_to_fp(b), 1'b1, int_to_fp(a + b), EXC_NONE);
			run_op(FUNCT_SUB, int_to_fp(a), int_to_fp(b), 1'b1, int_to_fp(a - b), EXC_NONE);
		end
		repeat (4) begin
			a = $random(seed) % 2048;
			run_op(FUNCT_SUB, int_to_fp(a), int_to_fp(a), 1'b1, 32'h0, EXC_NONE);  // +0
		end

		repeat (n_rand) begin
			a   = $random(seed) % 2048;
			b   = $random(seed) % 2048;
			sgn = (a < 0) ^ (b < 0);  // zero products keep the sign too
			r   = int_to_fp(a * b);
			run_op(FUNCT_MUL, int_to_fp(a), int_to_fp(b), 1'b1, {sgn, r[30:0]}, EXC_NONE);
		end

		// exponent sums past 127 saturate to infinity
		run_op(FUNCT_MUL, pow2(100, 0), pow2(100, 0), 1'b1, {1'b0, EXP_MAX, 23'd0}, EXC_OVF);
		run_op(FUNCT_MUL, pow2(100, 1), pow2(100, 0), 1'b1, {1'b1, EXP_MAX, 23'd0}, EXC_OVF);
		run_op(FUNCT_MUL, pow2(64, 0), pow2(64, 0), 1'b1, {1'b0, EXP_MAX, 23'd0}, EXC_OVF);
		run_op(FUNCT_MUL, pow2(63, 0), pow2(64, 0), 1'b1, pow2(127, 0), EXC_NONE);

		// nan operands come back quiet
		run_op(FUNCT_ADD, 32'h7fa0_1234, int_to_fp(3), 1'b1, 32'h7fe0_1234, EXC_NONE);
		run_op(FUNCT_ADD, int_to_fp(1), 32'hffc0_0001, 1'b1, 32'hffc0_0001, EXC_NONE);
		run_op(FUNCT_SUB, 32'h7f80_0000, 32'h7f80_0000, 1'b1, FP_DEFAULT_NAN, EXC_NONE);
		run_op(FUNCT_MUL, 32'h0000_0000, 32'h7f80_0000, 1'b1, FP_DEFAULT_NAN, EXC_NONE);

		issue(OP1_COP1, FMT_S, 6'd3, int_to_fp(6), int_to_fp(2), 1'b0, '0, EXC_INVALID_OP);
		issue(6'b000000, FMT_S, FUNCT_ADD, int_to_fp(1), int_to_fp(1), 1'b0, '0, EXC_INVALID_OP);
		issue(OP1_COP1, 5'b10001, FUNCT_ADD, int_to_fp(1), int_to_fp(1), 1'b0, '0,
			EXC_INVALID_OP);

		drain_pipe();
		repeat (2) @(negedge clk);  // let the checker see the last outputs

		if (dut0.chk0.fails == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("Test FAILED");
			$fatal(1, "checker reported failures");
		end
	end

endmodule

/* build.f */
source/fp_pkg.sv
source/fpu_op_pkg.sv
source/fp_operand_if.sv
source/fp_unpack.sv
source/lead_zero_count.sv
source/fp_addsub.sv
source/fp_mul.sv
source/fpu_result_stage.sv
source/fpu_top.sv
test/fpu_checker.sv
test/fpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the simulation with verilator and run it; the exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module fpu_tb -f build.f -o fpu_sim \
	&& ./obj_dir/fpu_sim +verilator+error+limit+100 \
	|| { echo "simulation failed"; exit 1; }
